//--- all.f
exu_pkg.sv
exu_issue.sv
exu_alu.sv
exu_lsu.sv
exu_wb.sv
exu_top.sv
tb_exu.sv

//--- exu_alu.sv
`timescale 1ns/10ps

module exu_alu import exu_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 5
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic                  in_valid,
    input  op_class_e             in_class,
    input  alu_op_e               in_alu_op,
    input  br_op_e                in_br_op,
    input  mem_size_e             in_mem_size,
    input  logic                  in_mem_sext,
    input  logic [DATA_WIDTH-1:0] in_src1,
    input  logic [DATA_WIDTH-1:0] in_src2,
    input  logic [DATA_WIDTH-1:0] in_imm,
    input  logic [DATA_WIDTH-1:0] in_pc,
    input  logic [ADDR_WIDTH-1:0] in_rd,
    output logic                  s1_valid,
    output op_class_e             s1_class,
    output logic [ADDR_WIDTH-1:0] s1_rd,
    output logic [DATA_WIDTH-1:0] s1_result,
    output logic [DATA_WIDTH-1:0] s1_store_data,
    output mem_size_e             s1_mem_size,
    output logic                  s1_mem_sext,
    output logic                  s1_jump,
    output logic [DATA_WIDTH-1:0] s1_jump_pc
);

    logic [4:0]            shamt;
    logic [DATA_WIDTH-1:0] alu_res;
    logic [DATA_WIDTH-1:0] sum_imm;
    logic [DATA_WIDTH-1:0] link;
    logic                  taken;
    logic [DATA_WIDTH-1:0] result;
    logic                  jump;
    logic [DATA_WIDTH-1:0] target;

    assign shamt   = in_src2[4:0];
    assign sum_imm = in_src1 + in_imm;
    assign link    = in_pc + DATA_WIDTH'(4);

    always_comb begin
        case (in_alu_op)
            ALU_ADD:  alu_res = in_src1 + in_src2;
            ALU_SUB:  alu_res = in_src1 - in_src2;
            ALU_AND:  alu_res = in_src1 & in_src2;
            ALU_OR:   alu_res = in_src1 | in_src2;
            ALU_XOR:  alu_res = in_src1 ^ in_src2;
            ALU_SLL:  alu_res = in_src1 << shamt;
            ALU_SRL:  alu_res = in_src1 >> shamt;
            ALU_SRA:  alu_res = $signed(in_src1) >>> shamt;
            ALU_SLT:  alu_res = DATA_WIDTH'($signed(in_src1) < $signed(in_src2));
            ALU_SLTU: alu_res = DATA_WIDTH'(in_src1 < in_src2);
            default:  alu_res = '0;
        endcase
    end

    always_comb begin
        case (in_br_op)
            BR_BEQ:  taken = (in_src1 == in_src2);
            BR_BNE:  taken = (in_src1 != in_src2);
            BR_BLT:  taken = ($signed(in_src1) < $signed(in_src2));
            BR_BGE:  taken = ($signed(in_src1) >= $signed(in_src2));
            BR_BLTU: taken = (in_src1 < in_src2);
            BR_BGEU: taken = (in_src1 >= in_src2);
            default: taken = 1'b0;
        endcase
    end

    // Memory ops carry their address in the result field.
    always_comb begin
        result = alu_res;
        jump   = 1'b0;
        target = in_pc + in_imm;
        case (in_class)
            OP_LOAD, OP_STORE: result = sum_imm;
            OP_BRANCH:         jump = taken;
            OP_JAL: begin
                result = link;
                jump   = 1'b1;
            end
            OP_JALR: begin
                result = link;
                jump   = 1'b1;
                target = sum_imm & ~DATA_WIDTH'(1);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && in_valid) begin
            s1_class      <= in_class;
            s1_rd         <= in_rd;
            s1_result     <= result;
            s1_store_data <= in_src2;
            s1_mem_size   <= in_mem_size;
            s1_mem_sext   <= in_mem_sext;
            s1_jump       <= jump;
            s1_jump_pc    <= target;
        end
    end

endmodule

//--- exu_issue.sv
`timescale 1ns/10ps

module exu_issue import exu_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 5
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  iss_req,
    input  op_class_e             op_class,
    input  alu_op_e               alu_op,
    input  br_op_e                br_op,
    input  mem_size_e             mem_size,
    input  logic                  mem_sext,
    input  logic [DATA_WIDTH-1:0] src1,
    input  logic [DATA_WIDTH-1:0] src2,
    input  logic [DATA_WIDTH-1:0] imm,
    input  logic [DATA_WIDTH-1:0] pc,
    input  logic [ADDR_WIDTH-1:0] rd,
    input  logic                  stall,
    output logic                  iss_ack,
    output logic                  in_valid,
    output op_class_e             in_class,
    output alu_op_e               in_alu_op,
    output br_op_e                in_br_op,
    output mem_size_e             in_mem_size,
    output logic                  in_mem_sext,
    output logic [DATA_WIDTH-1:0] in_src1,
    output logic [DATA_WIDTH-1:0] in_src2,
    output logic [DATA_WIDTH-1:0] in_imm,
    output logic [DATA_WIDTH-1:0] in_pc,
    output logic [ADDR_WIDTH-1:0] in_rd
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACK,
        S_WAIT
    } state_e;

    state_e state;
    logic   accept;
    logic   pend;

    assign accept   = (state == S_IDLE) && iss_req && !stall;
    assign iss_ack  = (state != S_IDLE);
    assign in_valid = pend;

    // ********************
    // Four-phase receiver.
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        state <= S_ACK;
                    end
                end
                S_ACK:   state <= iss_req ? S_WAIT : S_IDLE;
                default: begin
                    if (!iss_req) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // Entry stays pending until stage one is free to take it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= 1'b0;
        end else if (accept) begin
            pend <= 1'b1;
        end else if (!stall) begin
            pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            in_class    <= op_class;
            in_alu_op   <= alu_op;
            in_br_op    <= br_op;
            in_mem_size <= mem_size;
            in_mem_sext <= mem_sext;
            in_src1     <= src1;
            in_src2     <= src2;
            in_imm      <= imm;
            in_pc       <= pc;
            in_rd       <= rd;
        end
    end

    // The source may not withdraw a request that has not been acknowledged.
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        iss_req && !iss_ack |=> iss_req || iss_ack);

endmodule

//--- exu_lsu.sv
`timescale 1ns/10ps

module exu_lsu import exu_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 5,
    parameter int DMEM_WORDS = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic                  s1_valid,
    input  op_class_e             s1_class,
    input  logic [ADDR_WIDTH-1:0] s1_rd,
    input  logic [DATA_WIDTH-1:0] s1_result,
    input  logic [DATA_WIDTH-1:0] s1_store_data,
    input  mem_size_e             s1_mem_size,
    input  logic                  s1_mem_sext,
    input  logic                  s1_jump,
    input  logic [DATA_WIDTH-1:0] s1_jump_pc,
    output logic                  s2_valid,
    output op_class_e             s2_class,
    output logic [ADDR_WIDTH-1:0] s2_rd,
    output logic [DATA_WIDTH-1:0] s2_data,
    output logic                  s2_jump,
    output logic [DATA_WIDTH-1:0] s2_jump_pc
);

    localparam int NB    = DATA_WIDTH / 8;
    localparam int OFF_W = $clog2(NB);
    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [DATA_WIDTH-1:0] mem [DMEM_WORDS];

    logic [OFF_W-1:0]      off;
    logic [IDX_W-1:0]      idx;
    logic                  st_en;
    logic [NB-1:0]         be;
    logic [DATA_WIDTH-1:0] wdata;
    logic [DATA_WIDTH-1:0] lane;
    logic [DATA_WIDTH-1:0] ld_data;

    assign off   = s1_result[OFF_W-1:0];
    assign idx   = s1_result[OFF_W +: IDX_W];
    assign st_en = s1_valid && !stall && (s1_class == OP_STORE);

    // ********************
    // Store lane merge.
    // ********************
    always_comb begin
        case (s1_mem_size)
            MEM_BYTE: begin
                be    = NB'(1) << off;
                wdata = {NB{s1_store_data[7:0]}};
            end
            MEM_HALF: begin
                be    = NB'(3) << off;
                wdata = {(NB/2){s1_store_data[15:0]}};
            end
            default: begin
                be    = '1;
                wdata = s1_store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (st_en) begin
            for (int i = 0; i < NB; i++) begin
                if (be[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Addressed byte or half lands in the low bits.
    always_comb begin
        lane = mem[idx] >> {off, 3'b000};
        case (s1_mem_size)
            MEM_BYTE: ld_data = {{(DATA_WIDTH-8){s1_mem_sext & lane[7]}}, lane[7:0]};
            MEM_HALF: ld_data = {{(DATA_WIDTH-16){s1_mem_sext & lane[15]}}, lane[15:0]};
            default:  ld_data = lane;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else if (!stall) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && s1_valid) begin
            s2_class   <= s1_class;
            s2_rd      <= s1_rd;
            s2_data    <= (s1_class == OP_LOAD) ? ld_data : s1_result;
            s2_jump    <= s1_jump;
            s2_jump_pc <= s1_jump_pc;
        end
    end

    // Issued addresses must be naturally aligned for their size.
    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        s1_valid && (s1_class inside {OP_LOAD, OP_STORE}) |->
            ((s1_mem_size != MEM_HALF) || !s1_result[0]) &&
            ((s1_mem_size != MEM_WORD) || (s1_result[1:0] == 2'b00)));

endmodule

//--- exu_pkg.sv
package exu_pkg;

    // ********************
    // Enumeration widths.
    // ********************
    localparam int OP_CLASS_W = 3;
    localparam int ALU_OP_W   = 4;
    localparam int BR_OP_W    = 3;
    localparam int MEM_SIZE_W = 2;

    // Kind of operation carried down the pipe.
    typedef enum logic [OP_CLASS_W-1:0] {
        OP_ALU    = 3'd0,
        OP_LOAD   = 3'd1,
        OP_STORE  = 3'd2,
        OP_BRANCH = 3'd3,
        OP_JAL    = 3'd4,
        OP_JALR   = 3'd5
    } op_class_e;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic [BR_OP_W-1:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd2,
        BR_BGE  = 3'd3,
        BR_BLTU = 3'd4,
        BR_BGEU = 3'd5
    } br_op_e;

    typedef enum logic [MEM_SIZE_W-1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

endpackage

//--- exu_top.sv
`timescale 1ns/10ps

module exu_top import exu_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 5,
    parameter int DMEM_WORDS = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  iss_req,
    input  op_class_e             op_class,
    input  alu_op_e               alu_op,
    input  br_op_e                br_op,
    input  mem_size_e             mem_size,
    input  logic                  mem_sext,
    input  logic [DATA_WIDTH-1:0] src1,
    input  logic [DATA_WIDTH-1:0] src2,
    input  logic [DATA_WIDTH-1:0] imm,
    input  logic [DATA_WIDTH-1:0] pc,
    input  logic [ADDR_WIDTH-1:0] rd,
    output logic                  iss_ack,
    output logic                  res_req,
    output logic                  res_rd_wen,
    output logic [ADDR_WIDTH-1:0] res_rd_addr,
    output logic [DATA_WIDTH-1:0] res_rd_data,
    output logic                  res_jump,
    output logic [DATA_WIDTH-1:0] res_jump_pc,
    input  logic                  res_ack
);

    logic                  stall;

    logic                  in_valid;
    op_class_e             in_class;
    alu_op_e               in_alu_op;
    br_op_e                in_br_op;
    mem_size_e             in_mem_size;
    logic                  in_mem_sext;
    logic [DATA_WIDTH-1:0] in_src1;
    logic [DATA_WIDTH-1:0] in_src2;
    logic [DATA_WIDTH-1:0] in_imm;
    logic [DATA_WIDTH-1:0] in_pc;
    logic [ADDR_WIDTH-1:0] in_rd;

    logic                  s1_valid;
    op_class_e             s1_class;
    logic [ADDR_WIDTH-1:0] s1_rd;
    logic [DATA_WIDTH-1:0] s1_result;
    logic [DATA_WIDTH-1:0] s1_store_data;
    mem_size_e             s1_mem_size;
    logic                  s1_mem_sext;
    logic                  s1_jump;
    logic [DATA_WIDTH-1:0] s1_jump_pc;

    logic                  s2_valid;
    op_class_e             s2_class;
    logic [ADDR_WIDTH-1:0] s2_rd;
    logic [DATA_WIDTH-1:0] s2_data;
    logic                  s2_jump;
    logic [DATA_WIDTH-1:0] s2_jump_pc;

    exu_issue #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .iss_req     (iss_req),
        .op_class    (op_class),
        .alu_op      (alu_op),
        .br_op       (br_op),
        .mem_size    (mem_size),
        .mem_sext    (mem_sext),
        .src1        (src1),
        .src2        (src2),
        .imm         (imm),
        .pc          (pc),
        .rd          (rd),
        .stall       (stall),
        .iss_ack     (iss_ack),
        .in_valid    (in_valid),
        .in_class    (in_class),
        .in_alu_op   (in_alu_op),
        .in_br_op    (in_br_op),
        .in_mem_size (in_mem_size),
        .in_mem_sext (in_mem_sext),
        .in_src1     (in_src1),
        .in_src2     (in_src2),
        .in_imm      (in_imm),
        .in_pc       (in_pc),
        .in_rd       (in_rd)
    );

    exu_alu #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_alu (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .in_valid      (in_valid),
        .in_class      (in_class),
        .in_alu_op     (in_alu_op),
        .in_br_op      (in_br_op),
        .in_mem_size   (in_mem_size),
        .in_mem_sext   (in_mem_sext),
        .in_src1       (in_src1),
        .in_src2       (in_src2),
        .in_imm        (in_imm),
        .in_pc         (in_pc),
        .in_rd         (in_rd),
        .s1_valid      (s1_valid),
        .s1_class      (s1_class),
        .s1_rd         (s1_rd),
        .s1_result     (s1_result),
        .s1_store_data (s1_store_data),
        .s1_mem_size   (s1_mem_size),
        .s1_mem_sext   (s1_mem_sext),
        .s1_jump       (s1_jump),
        .s1_jump_pc    (s1_jump_pc)
    );

    exu_lsu #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .DMEM_WORDS (DMEM_WORDS)
    ) u_lsu (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .s1_valid      (s1_valid),
        .s1_class      (s1_class),
        .s1_rd         (s1_rd),
        .s1_result     (s1_result),
        .s1_store_data (s1_store_data),
        .s1_mem_size   (s1_mem_size),
        .s1_mem_sext   (s1_mem_sext),
        .s1_jump       (s1_jump),
        .s1_jump_pc    (s1_jump_pc),
        .s2_valid      (s2_valid),
        .s2_class      (s2_class),
        .s2_rd         (s2_rd),
        .s2_data       (s2_data),
        .s2_jump       (s2_jump),
        .s2_jump_pc    (s2_jump_pc)
    );

    exu_wb #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_wb (
        .clk         (clk),
        .rst_n       (rst_n),
        .s2_valid    (s2_valid),
        .s2_class    (s2_class),
        .s2_rd       (s2_rd),
        .s2_data     (s2_data),
        .s2_jump     (s2_jump),
        .s2_jump_pc  (s2_jump_pc),
        .res_ack     (res_ack),
        .stall       (stall),
        .res_req     (res_req),
        .res_rd_wen  (res_rd_wen),
        .res_rd_addr (res_rd_addr),
        .res_rd_data (res_rd_data),
        .res_jump    (res_jump),
        .res_jump_pc (res_jump_pc)
    );

endmodule

//--- exu_wb.sv
`timescale 1ns/10ps

module exu_wb import exu_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 5
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  s2_valid,
    input  op_class_e             s2_class,
    input  logic [ADDR_WIDTH-1:0] s2_rd,
    input  logic [DATA_WIDTH-1:0] s2_data,
    input  logic                  s2_jump,
    input  logic [DATA_WIDTH-1:0] s2_jump_pc,
    input  logic                  res_ack,
    output logic                  stall,
    output logic                  res_req,
    output logic                  res_rd_wen,
    output logic [ADDR_WIDTH-1:0] res_rd_addr,
    output logic [DATA_WIDTH-1:0] res_rd_data,
    output logic                  res_jump,
    output logic [DATA_WIDTH-1:0] res_jump_pc
);

    logic wen;

    // x0 is never written.
    assign wen = (s2_class inside {OP_ALU, OP_LOAD, OP_JAL, OP_JALR}) && (s2_rd != '0);

    // Hold the pipe until ack has come and gone.
    assign stall = res_req | res_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_req <= 1'b0;
        end else if (res_req && res_ack) begin
            res_req <= 1'b0;
        end else if (!stall) begin
            res_req <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && s2_valid) begin
            res_rd_wen  <= wen;
            res_rd_addr <= wen ? s2_rd : '0;
            res_rd_data <= wen ? s2_data : '0;
            res_jump    <= s2_jump;
            res_jump_pc <= s2_jump ? s2_jump_pc : '0;
        end
    end

    a_res_stable: assert property (@(posedge clk) disable iff (!rst_n)
        res_req |=> !res_req ||
            $stable({res_rd_wen, res_rd_addr, res_rd_data, res_jump, res_jump_pc}));

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_exu -f all.f -o tb_exu &&
./obj_dir/tb_exu ||
exit 1

//--- tb_exu.sv
`timescale 1ns/10ps

module tb_exu
    import exu_pkg::*;
();

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 5;
    localparam int DMEM_WORDS = 64;
    localparam int MEM_BYTES  = DMEM_WORDS * 4;
    localparam int BA_W       = $clog2(MEM_BYTES);
    localparam int N_RANDOM   = 300;
    localparam int N_OPS      = DMEM_WORDS + N_RANDOM;
    localparam int TIMEOUT    = N_OPS * 20;

    typedef struct packed {
        logic                  wen;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic                  jump;
        logic [DATA_WIDTH-1:0] jump_pc;
    } result_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  iss_req;
    op_class_e             op_class;
    alu_op_e               alu_op;
    br_op_e                br_op;
    mem_size_e             mem_size;
    logic                  mem_sext;
    logic [DATA_WIDTH-1:0] src1;
    logic [DATA_WIDTH-1:0] src2;
    logic [DATA_WIDTH-1:0] imm;
    logic [DATA_WIDTH-1:0] pc;
    logic [ADDR_WIDTH-1:0] rd;
    logic                  iss_ack;
    logic                  res_req;
    logic                  res_rd_wen;
    logic [ADDR_WIDTH-1:0] res_rd_addr;
    logic [DATA_WIDTH-1:0] res_rd_data;
    logic                  res_jump;
    logic [DATA_WIDTH-1:0] res_jump_pc;
    logic                  res_ack;

    result_t     exp_q[$];
    string       name_q[$];
    logic [7:0]  mirror [MEM_BYTES];
    int          n_issued = 0;
    int          n_checked = 0;
    int          cycles = 0;
    logic [31:0] stim_seed = 32'd73581;
    logic [31:0] ack_seed = 32'd73581;
    result_t     held;
    logic        req_prev = 1'b0;
    logic        ack_prev = 1'b0;
    logic        res_prev = 1'b0;
    logic        req_seen = 1'b0;

    exu_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH),
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .iss_req     (iss_req),
        .op_class    (op_class),
        .alu_op      (alu_op),
        .br_op       (br_op),
        .mem_size    (mem_size),
        .mem_sext    (mem_sext),
        .src1        (src1),
        .src2        (src2),
        .imm         (imm),
        .pc          (pc),
        .rd          (rd),
        .iss_ack     (iss_ack),
        .res_req     (res_req),
        .res_rd_wen  (res_rd_wen),
        .res_rd_addr (res_rd_addr),
        .res_rd_data (res_rd_data),
        .res_jump    (res_jump),
        .res_jump_pc (res_jump_pc),
        .res_ack     (res_ack)
    );

    always #20 clk = ~clk;

    // ********************
    // Error reporting.
    // ********************
    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] want, input logic [31:0] got);
        $display("FAIL %s %s: expected %h, actual %h", name, field, want, got);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string text);
        $display("Error: %s", text);
        $display("Verification failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_word();
        stim_seed = lcg_next(stim_seed);
        return stim_seed;
    endfunction

    // Upper bits of the LCG are the better distributed ones.
    function automatic int unsigned pick(input int unsigned n);
        stim_seed = lcg_next(stim_seed);
        return (stim_seed >> 8) % n;
    endfunction

    // ********************
    // Reference model.
    // ********************
    function automatic logic [31:0] expected_alu(input alu_op_e op, input logic [31:0] a,
                                                 input logic [31:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'b0, a < b};
            default:  return 32'h0;
        endcase
    endfunction

    function automatic logic expected_taken(input br_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return !($signed(a) < $signed(b));
            BR_BLTU: return a < b;
            BR_BGEU: return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    // Stores update the byte mirror, so calls must follow issue order.
    function automatic result_t predict_result(input op_class_e cls, input alu_op_e aop,
                                               input br_op_e bop, input mem_size_e sz,
                                               input logic sx, input logic [31:0] a,
                                               input logic [31:0] b, input logic [31:0] im,
                                               input logic [31:0] p, input logic [4:0] r);
        result_t         res;
        logic [31:0]     value;
        logic [31:0]     ea;
        logic [BA_W-1:0] ba;
        logic            writes;
        int              nbytes;
        ea = a + im;
        value = 32'h0;
        res.jump = 1'b0;
        res.jump_pc = 32'h0;
        nbytes = (sz == MEM_BYTE) ? 1 : ((sz == MEM_HALF) ? 2 : 4);
        case (cls)
            OP_ALU: value = expected_alu(aop, a, b);
            OP_LOAD: begin
                for (int i = 0; i < nbytes; i++) begin
                    ba = BA_W'(ea + 32'(i));
                    value[8*i +: 8] = mirror[ba];
                end
                if (sx && nbytes == 1) begin
                    value = {{24{value[7]}}, value[7:0]};
                end else if (sx && nbytes == 2) begin
                    value = {{16{value[15]}}, value[15:0]};
                end
            end
            OP_STORE: begin
                for (int i = 0; i < nbytes; i++) begin
                    ba = BA_W'(ea + 32'(i));
                    mirror[ba] = b[8*i +: 8];
                end
            end
            OP_BRANCH: begin
                res.jump = expected_taken(bop, a, b);
                res.jump_pc = res.jump ? p + im : 32'h0;
            end
            OP_JAL: begin
                value = p + 32'd4;
                res.jump = 1'b1;
                res.jump_pc = p + im;
            end
            OP_JALR: begin
                value = p + 32'd4;
                res.jump = 1'b1;
                res.jump_pc = ea & 32'hffff_fffe;
            end
            default: ;
        endcase
        writes = (cls inside {OP_ALU, OP_LOAD, OP_JAL, OP_JALR}) && (r != 5'd0);
        res.wen = writes;
        res.addr = writes ? r : 5'd0;
        res.data = writes ? value : 32'h0;
        return res;
    endfunction

    // ********************
    // Stimulus.
    // ********************
    task automatic send_op(input op_class_e cls, input alu_op_e aop, input br_op_e bop,
                           input mem_size_e sz, input logic sx, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] im, input logic [31:0] p,
                           input logic [4:0] r, input string name);
        int unsigned hold;
        exp_q.push_back(predict_result(cls, aop, bop, sz, sx, a, b, im, p, r));
        name_q.push_back(name);
        n_issued++;
        // Sometimes keep iss_req up past the acknowledge.
        hold = pick(3);
        @(posedge clk);
        #2;
        op_class = cls;
        alu_op   = aop;
        br_op    = bop;
        mem_size = sz;
        mem_sext = sx;
        src1     = a;
        src2     = b;
        imm      = im;
        pc       = p;
        rd       = r;
        iss_req  = 1'b1;
        do begin
            @(posedge clk);
            #2;
        end while (!iss_ack);
        repeat (hold) begin
            @(posedge clk);
            #2;
        end
        iss_req = 1'b0;
        do begin
            @(posedge clk);
            #2;
        end while (iss_ack);
    endtask

    task automatic build_random_op(input int n);
        op_class_e   cls;
        alu_op_e     aop;
        br_op_e      bop;
        mem_size_e   sz;
        logic        sx;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] im;
        logic [31:0] p;
        logic [31:0] ea;
        logic [4:0]  r;
        cls = op_class_e'(3'(pick(6)));
        aop = alu_op_e'(4'(pick(10)));
        bop = br_op_e'(3'(pick(6)));
        sz  = mem_size_e'(2'(pick(3)));
        sx  = 1'(pick(2));
        a   = rand_word();
        b   = rand_word();
        im  = rand_word();
        p   = rand_word() & 32'hffff_fffc;
        r   = 5'(pick(32));
        if (pick(8) == 0) begin
            r = 5'd0;
        end
        // Equal operands so that beq and bge see their edge cases.
        if (pick(4) == 0) begin
            b = a;
        end
        if (cls inside {OP_LOAD, OP_STORE}) begin
            ea = 32'(pick(MEM_BYTES));
            if (sz == MEM_HALF) begin
                ea[0] = 1'b0;
            end else if (sz == MEM_WORD) begin
                ea[1:0] = 2'b00;
            end
            im = ea - a;
        end
        send_op(cls, aop, bop, sz, sx, a, b, im, p, r, $sformatf("op%0d %s", n, cls.name()));
    endtask

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] d;
        rst_n    = 1'b0;
        iss_req  = 1'b0;
        op_class = OP_ALU;
        alu_op   = ALU_ADD;
        br_op    = BR_BEQ;
        mem_size = MEM_WORD;
        mem_sext = 1'b0;
        src1     = '0;
        src2     = '0;
        imm      = '0;
        pc       = '0;
        rd       = '0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // Fill every data memory word before any load reads it.
        for (int w = 0; w < DMEM_WORDS; w++) begin
            a = rand_word();
            d = rand_word();
            send_op(OP_STORE, ALU_ADD, BR_BEQ, MEM_WORD, 1'b0, a, d, 32'(4 * w) - a,
                    32'h0, 5'd0, $sformatf("fill%0d", w));
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            build_random_op(n);
        end
        while (n_checked < n_issued) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        assert (n_checked == n_issued && exp_q.size() == 0)
            else abort_run($sformatf("%0d results for %0d issued operations",
                                     n_checked, n_issued));
        $display("Verification passed");
        $finish;
    end

    // Acknowledge each result after 0 to 5 cycles.
    initial begin : ack_responder
        int unsigned delay;
        res_ack = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (res_req && !res_ack) begin
                ack_seed = lcg_next(ack_seed);
                delay = (ack_seed >> 8) % 6;
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                res_ack = 1'b1;
                do begin
                    @(posedge clk);
                    #2;
                end while (res_req);
                res_ack = 1'b0;
            end
        end
    end

    // ********************
    // Checker.
    // ********************
    always @(negedge clk) begin : result_checker
        result_t want;
        result_t cur;
        string   name;
        cur.wen     = res_rd_wen;
        cur.addr    = res_rd_addr;
        cur.data    = res_rd_data;
        cur.jump    = res_jump;
        cur.jump_pc = res_jump_pc;
        if (!rst_n) begin
            assert (!iss_ack && !res_req)
                else abort_run("iss_ack or res_req high during reset");
        end else begin
            if (!req_seen) begin
                assert (!iss_ack && !res_req)
                    else abort_run("iss_ack or res_req high before the first iss_req");
            end
            if (iss_ack && !ack_prev) begin
                assert (req_prev) else abort_run("iss_ack rose without iss_req");
            end
            if (!iss_ack && ack_prev) begin
                assert (!req_prev) else abort_run("iss_ack fell while iss_req was high");
            end
            if (res_req && !res_prev) begin
                assert (exp_q.size() > 0) else abort_run("result with no operation pending");
                want = exp_q.pop_front();
                name = name_q.pop_front();
                assert (cur.wen == want.wen)
                    else report_mismatch(name, "rd_wen", 32'(want.wen), 32'(cur.wen));
                assert (cur.addr == want.addr)
                    else report_mismatch(name, "rd_addr", 32'(want.addr), 32'(cur.addr));
                assert (cur.data == want.data)
                    else report_mismatch(name, "rd_data", want.data, cur.data);
                assert (cur.jump == want.jump)
                    else report_mismatch(name, "jump", 32'(want.jump), 32'(cur.jump));
                assert (cur.jump_pc == want.jump_pc)
                    else report_mismatch(name, "jump_pc", want.jump_pc, cur.jump_pc);
                held = cur;
                n_checked++;
            end else if (res_req) begin
                assert (cur == held) else abort_run("result fields changed while res_req high");
            end
        end
        if (iss_req) begin
            req_seen = 1'b1;
        end
        req_prev = iss_req;
        ack_prev = iss_ack;
        res_prev = res_req;
    end

    always @(posedge clk) begin : watchdog
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            abort_run($sformatf("timeout after %0d cycles", cycles));
        end
    end

endmodule
